//--- cpu_control.sv
`timescale 1ns/10ps

module cpu_control (
    input  lc3b_types::lc3b_opcode         opcode,
    input  logic                           ir_4,
    input  logic                           ir_5,
    input  logic                           ir_11,
    output logic                           src2mux_sel,
    output lc3b_types::lc3b_aluop          aluop,
    output lc3b_types::lc3b_alumux_sel     alumux_sel,
    output logic                           d_mem_read,
    output logic                           d_mem_write,
    output lc3b_types::lc3b_regfilemux_sel regfilemux_sel,
    output logic                           load_regfile,
    output logic                           load_cc
);
    import lc3b_types::*;

    always_comb begin
        // defaults describe a bubble
        src2mux_sel    = 1'b0;              // sr2 from ir[2:0]
        aluop          = alu_pass;
        alumux_sel     = 2'b00;             // src2
        d_mem_read     = 1'b0;
        d_mem_write    = 1'b0;
        regfilemux_sel = 2'b00;             // alu result
        load_regfile   = 1'b0;
        load_cc        = 1'b0;

        case (opcode)
            op_add: begin
                aluop        = alu_add;
                alumux_sel   = ir_5 ? 2'b10 : 2'b00;   // imm5 or src2
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end
            op_and: begin
                aluop        = alu_and;
                alumux_sel   = ir_5 ? 2'b10 : 2'b00;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end
            op_not: begin
                aluop        = alu_not;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end
            op_shf: begin
                case ({ir_4, ir_5})
                    2'b10:   aluop = alu_srl;
                    2'b11:   aluop = alu_sra;        // sign fill
                    default: aluop = alu_sll;        // left shift ignores ir_5
                endcase
                alumux_sel   = 2'b01;                // imm4 is the amount
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end
            op_ldr: begin
                aluop          = alu_add;            // base + offset6 << 1
                alumux_sel     = 2'b11;
                d_mem_read     = 1'b1;
                regfilemux_sel = 2'b01;              // memory data
                load_regfile   = 1'b1;
                load_cc        = 1'b1;
            end
            op_str: begin
                src2mux_sel = 1'b1;                  // store data from ir[11:9]
                aluop       = alu_add;
                alumux_sel  = 2'b11;
                d_mem_write = 1'b1;
            end
            op_lea: begin
                regfilemux_sel = 2'b10;              // pc + offset9
                load_regfile   = 1'b1;
                load_cc        = 1'b1;
            end
            default: ;                               // no fetch path, so nothing to do
        endcase
    end

    // a single data port cannot read and write in one memory cycle
    rw_exclusive: assert final (!(d_mem_read && d_mem_write))
        else $error("read and write both decoded, opcode %b ir_11/5/4 %b%b%b",
                    opcode, ir_11, ir_5, ir_4);

endmodule : cpu_control

//--- lc3b_consts.svh
`ifndef LC3B_CONSTS_SVH
`define LC3B_CONSTS_SVH

`define LC3B_RAM_WORDS   256        // data ram depth in 16-bit words
`define LC3B_WB_LATENCY  3          // acceptance edge to wb_valid cycle
`define LC3B_RESET_PC    16'h0000   // first accepted instruction sits here

`endif

//--- lc3b_execute.sv
`timescale 1ns/10ps

module lc3b_execute (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           valid_ex,
    input  lc3b_types::lc3b_word           instr_ex,
    input  lc3b_types::lc3b_word           pc_ex,        // already pc + 2
    input  lc3b_types::lc3b_word           src1_ex,
    input  lc3b_types::lc3b_word           src2_ex,
    input  lc3b_types::lc3b_aluop          aluop_ex,
    input  lc3b_types::lc3b_alumux_sel     alumux_sel_ex,
    input  logic                           d_mem_read_ex,
    input  logic                           d_mem_write_ex,
    input  lc3b_types::lc3b_regfilemux_sel regfilemux_sel_ex,
    input  logic                           load_regfile_ex,
    input  logic                           load_cc_ex,
    output logic                           valid_mem,
    output lc3b_types::lc3b_word           alu_mem,
    output lc3b_types::lc3b_word           addr_mem,
    output lc3b_types::lc3b_word           sdata_mem,
    output lc3b_types::lc3b_word           pcoff_mem,
    output lc3b_types::lc3b_reg            dest_mem,
    output logic                           d_mem_read_mem,
    output logic                           d_mem_write_mem,
    output lc3b_types::lc3b_regfilemux_sel regfilemux_sel_mem,
    output logic                           load_regfile_mem,
    output logic                           load_cc_mem
);
    import lc3b_types::*;

    lc3b_word imm4, imm5, off6, off9;
    lc3b_word alu_b, alu_out;

    assign imm4 = {12'b0, instr_ex[3:0]};                   // shift amount
    assign imm5 = {{11{instr_ex[4]}}, instr_ex[4:0]};
    assign off6 = {{9{instr_ex[5]}}, instr_ex[5:0], 1'b0};  // words to bytes
    assign off9 = {{6{instr_ex[8]}}, instr_ex[8:0], 1'b0};

    always_comb begin
        case (alumux_sel_ex)
            2'b01:   alu_b = imm4;
            2'b10:   alu_b = imm5;
            2'b11:   alu_b = off6;
            default: alu_b = src2_ex;
        endcase
    end

    always_comb begin
        case (aluop_ex)
            alu_add: alu_out = src1_ex + alu_b;
            alu_and: alu_out = src1_ex & alu_b;
            alu_not: alu_out = ~src1_ex;
            alu_sll: alu_out = src1_ex << alu_b[3:0];
            alu_srl: alu_out = src1_ex >> alu_b[3:0];
            alu_sra: alu_out = $signed(src1_ex) >>> alu_b[3:0];
            default: alu_out = alu_b;                       // pass
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_mem <= 1'b0;
        end else begin
            valid_mem <= valid_ex;
        end
    end

    // downstream uses these only while valid_mem is high
    always_ff @(posedge clk) begin
        if (valid_ex) begin
            alu_mem            <= alu_out;
            addr_mem           <= {alu_out[15:1], 1'b0};    // word aligned
            sdata_mem          <= src2_ex;
            pcoff_mem          <= pc_ex + off9;             // lea target
            dest_mem           <= instr_ex[11:9];
            d_mem_read_mem     <= d_mem_read_ex;
            d_mem_write_mem    <= d_mem_write_ex;
            regfilemux_sel_mem <= regfilemux_sel_ex;
            load_regfile_mem   <= load_regfile_ex;
            load_cc_mem        <= load_cc_ex;
        end
    end

    aluop_known: assert property (@(posedge clk) disable iff (reset)
        valid_ex |-> !$isunknown(aluop_ex))
        else $error("aluop unknown on a valid instruction in execute");

endmodule : lc3b_execute

//--- lc3b_mem_wb.sv
`timescale 1ns/10ps
`include "lc3b_consts.svh"

module lc3b_mem_wb (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           valid_mem,
    input  lc3b_types::lc3b_word           alu_mem,
    input  lc3b_types::lc3b_word           addr_mem,
    input  lc3b_types::lc3b_word           sdata_mem,
    input  lc3b_types::lc3b_word           pcoff_mem,
    input  lc3b_types::lc3b_reg            dest_mem,
    input  logic                           d_mem_read,
    input  logic                           d_mem_write,
    input  lc3b_types::lc3b_regfilemux_sel regfilemux_sel,
    input  logic                           load_regfile,
    input  logic                           load_cc,
    output logic                           st_valid,
    output lc3b_types::lc3b_word           st_addr,
    output lc3b_types::lc3b_word           st_data,
    output logic                           wb_valid,
    output lc3b_types::lc3b_reg            wb_dest,
    output lc3b_types::lc3b_word           wb_data,
    output lc3b_types::lc3b_nzp            cc
);
    import lc3b_types::*;

    lc3b_word           ram [`LC3B_RAM_WORDS];
    lc3b_word           rdata;
    logic               valid_wb, load_regfile_wb, load_cc_wb;
    lc3b_reg            dest_wb;
    lc3b_word           alu_wb, mdr_wb, pcoff_wb;
    lc3b_regfilemux_sel regfilemux_sel_wb;
    lc3b_nzp            nzp;

    assign rdata = ram[addr_mem[8:1]];                  // async read by word index

    always_ff @(posedge clk) begin
        if (valid_mem && d_mem_write) begin
            ram[addr_mem[8:1]] <= sdata_mem;
        end
    end

    assign st_valid = valid_mem & d_mem_write;
    assign st_addr  = addr_mem;
    assign st_data  = sdata_mem;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_wb <= 1'b0;
        end else begin
            valid_wb <= valid_mem;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_mem) begin
            dest_wb           <= dest_mem;
            alu_wb            <= alu_mem;
            pcoff_wb          <= pcoff_mem;
            regfilemux_sel_wb <= regfilemux_sel;
            load_regfile_wb   <= load_regfile;
            load_cc_wb        <= load_cc;
            if (d_mem_read) begin
                mdr_wb <= rdata;                        // only loads need it
            end
        end
    end

    always_comb begin
        case (regfilemux_sel_wb)
            2'b01:   wb_data = mdr_wb;
            2'b10:   wb_data = pcoff_wb;
            default: wb_data = alu_wb;
        endcase
    end

    assign wb_valid = valid_wb & load_regfile_wb;
    assign wb_dest  = dest_wb;

    assign nzp = {wb_data[15], wb_data == 16'h0000, !wb_data[15] && wb_data != 16'h0000};

    always_ff @(posedge clk) begin
        if (reset) begin
            cc <= 3'b000;
        end else if (valid_wb && load_cc_wb) begin
            cc <= nzp;                                  // one-hot once loaded
        end
    end

    wb_data_known: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> !$isunknown(wb_data))
        else $error("write-back of an unknown value to r%0d", wb_dest);

endmodule : lc3b_mem_wb

//--- lc3b_pipe.f
+incdir+.
lc3b_types.sv
cpu_control.sv
lc3b_regfile.sv
lc3b_execute.sv
lc3b_mem_wb.sv
lc3b_pipe.sv
tb_lc3b_pipe.sv

//--- lc3b_pipe.sv
`timescale 1ns/10ps
`include "lc3b_consts.svh"

module lc3b_pipe (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 instr_valid,
    input  lc3b_types::lc3b_word instr,
    output logic                 wb_valid,
    output lc3b_types::lc3b_reg  wb_dest,
    output lc3b_types::lc3b_word wb_data,
    output lc3b_types::lc3b_nzp  cc,
    output logic                 st_valid,
    output lc3b_types::lc3b_word st_addr,
    output lc3b_types::lc3b_word st_data
);
    import lc3b_types::*;

    lc3b_word           pc, pc_plus2, src1, src2;
    lc3b_reg            sr2;
    logic               src2mux_sel, d_mem_read, d_mem_write, load_regfile, load_cc;
    lc3b_aluop          aluop, aluop_ex;
    lc3b_alumux_sel     alumux_sel, alumux_sel_ex;
    lc3b_regfilemux_sel regfilemux_sel, regfilemux_sel_ex, regfilemux_sel_mem;
    logic               valid_ex, d_mem_read_ex, d_mem_write_ex, load_regfile_ex, load_cc_ex;
    lc3b_word           instr_ex, pc_ex, src1_ex, src2_ex;
    logic               valid_mem, d_mem_read_mem, d_mem_write_mem;
    logic               load_regfile_mem, load_cc_mem;
    lc3b_word           alu_mem, addr_mem, sdata_mem, pcoff_mem;
    lc3b_reg            dest_mem;

    assign pc_plus2 = pc + 16'd2;
    assign sr2      = src2mux_sel ? instr[11:9] : instr[2:0];  // str reads its source here

    cpu_control control (
        .opcode(lc3b_opcode'(instr[15:12])), .ir_4(instr[4]), .ir_5(instr[5]),
        .ir_11(instr[11]), .src2mux_sel(src2mux_sel), .aluop(aluop),
        .alumux_sel(alumux_sel), .d_mem_read(d_mem_read), .d_mem_write(d_mem_write),
        .regfilemux_sel(regfilemux_sel), .load_regfile(load_regfile), .load_cc(load_cc)
    );

    lc3b_regfile regfile (
        .clk(clk), .reset(reset), .load(wb_valid), .dest(wb_dest), .in_data(wb_data),
        .sr1(instr[8:6]), .sr2(sr2), .sr1_out(src1), .sr2_out(src2)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= `LC3B_RESET_PC;
            valid_ex <= 1'b0;
        end else begin
            valid_ex <= instr_valid;
            if (instr_valid) begin
                pc <= pc_plus2;                         // advances per accepted instr
            end
        end
    end

    // id/ex payload
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            instr_ex          <= instr;
            pc_ex             <= pc_plus2;
            src1_ex           <= src1;
            src2_ex           <= src2;
            aluop_ex          <= aluop;
            alumux_sel_ex     <= alumux_sel;
            d_mem_read_ex     <= d_mem_read;
            d_mem_write_ex    <= d_mem_write;
            regfilemux_sel_ex <= regfilemux_sel;
            load_regfile_ex   <= load_regfile;
            load_cc_ex        <= load_cc;
        end
    end

    lc3b_execute execute (
        .clk(clk), .reset(reset), .valid_ex(valid_ex), .instr_ex(instr_ex),
        .pc_ex(pc_ex), .src1_ex(src1_ex), .src2_ex(src2_ex), .aluop_ex(aluop_ex),
        .alumux_sel_ex(alumux_sel_ex), .d_mem_read_ex(d_mem_read_ex),
        .d_mem_write_ex(d_mem_write_ex), .regfilemux_sel_ex(regfilemux_sel_ex),
        .load_regfile_ex(load_regfile_ex), .load_cc_ex(load_cc_ex),
        .valid_mem(valid_mem), .alu_mem(alu_mem), .addr_mem(addr_mem),
        .sdata_mem(sdata_mem), .pcoff_mem(pcoff_mem), .dest_mem(dest_mem),
        .d_mem_read_mem(d_mem_read_mem), .d_mem_write_mem(d_mem_write_mem),
        .regfilemux_sel_mem(regfilemux_sel_mem), .load_regfile_mem(load_regfile_mem),
        .load_cc_mem(load_cc_mem)
    );

    lc3b_mem_wb mem_wb (
        .clk(clk), .reset(reset), .valid_mem(valid_mem), .alu_mem(alu_mem),
        .addr_mem(addr_mem), .sdata_mem(sdata_mem), .pcoff_mem(pcoff_mem),
        .dest_mem(dest_mem), .d_mem_read(d_mem_read_mem), .d_mem_write(d_mem_write_mem),
        .regfilemux_sel(regfilemux_sel_mem), .load_regfile(load_regfile_mem),
        .load_cc(load_cc_mem), .st_valid(st_valid), .st_addr(st_addr), .st_data(st_data),
        .wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data), .cc(cc)
    );

endmodule : lc3b_pipe

//--- lc3b_regfile.sv
`timescale 1ns/10ps

module lc3b_regfile (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load,
    input  lc3b_types::lc3b_reg  dest,
    input  lc3b_types::lc3b_word in_data,
    input  lc3b_types::lc3b_reg  sr1,
    input  lc3b_types::lc3b_reg  sr2,
    output lc3b_types::lc3b_word sr1_out,
    output lc3b_types::lc3b_word sr2_out
);
    import lc3b_types::*;

    lc3b_word regs [8];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (load) begin
            regs[dest] <= in_data;
        end
    end

    // write-through so decode sees this cycle's write-back
    assign sr1_out = (load && dest == sr1) ? in_data : regs[sr1];
    assign sr2_out = (load && dest == sr2) ? in_data : regs[sr2];

endmodule : lc3b_regfile

//--- lc3b_types.sv
package lc3b_types;

    typedef logic [15:0] lc3b_word;             // data or byte address
    typedef logic [2:0]  lc3b_reg;              // register index
    typedef logic [2:0]  lc3b_nzp;              // n at bit 2, p at bit 0

    // second alu operand: 00 src2 / 01 imm4 / 10 imm5 / 11 offset6 << 1
    typedef logic [1:0]  lc3b_alumux_sel;

    // write-back value: 00 alu / 01 memory data / 10 pc + offset9
    typedef logic [1:0]  lc3b_regfilemux_sel;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass,
        alu_sll,
        alu_srl,
        alu_sra
    } lc3b_aluop;

endpackage : lc3b_types

//--- tb_lc3b_pipe.sv
`timescale 1ns/10ps
`include "lc3b_consts.svh"

module tb_lc3b_pipe;
    import lc3b_types::*;

    localparam int N_ALU   = 200;
    localparam int N_SHF   = 48;
    localparam int N_MEM   = 792;   // base setups, data updates with stores, then loads
    localparam int N_LEA   = 32;
    localparam int N_MIX   = 96;
    localparam int N_TESTS = 6;
    localparam int LIMIT   = (N_ALU + N_SHF + N_MEM + N_LEA + N_MIX + 3 * N_TESTS + 20) * 2;

    logic     clk, reset, instr_valid, wb_valid, st_valid;
    lc3b_word instr, wb_data, st_addr, st_data;
    lc3b_reg  wb_dest;
    lc3b_nzp  cc;

    int       cyc = 0;
    int       errors = 0;
    int       tests = 0;
    integer   seed = 32'h6632_216a;

    lc3b_word m_regs [8];                   // reference model state
    lc3b_word m_ram [`LC3B_RAM_WORDS];
    lc3b_word m_pc;
    int       ready_cyc [8];                // first cycle a consumer may read it

    int       wq_due[$];                    // expected writes tagged with due cycle
    lc3b_reg  wq_dest[$];
    lc3b_word wq_data[$];
    lc3b_nzp  wq_cc[$];
    int       sq_due[$];                    // expected stores
    lc3b_word sq_addr[$];
    lc3b_word sq_data[$];

    logic     exp_wr = 1'b0;
    logic     exp_st = 1'b0;
    lc3b_reg  exp_dest;
    lc3b_word exp_data, exp_addr, exp_sdata;
    lc3b_nzp  exp_cc = 3'b000;

    lc3b_pipe DUT (
        .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
        .wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data), .cc(cc),
        .st_valid(st_valid), .st_addr(st_addr), .st_data(st_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    function automatic int unsigned urand(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic lc3b_word sext(input lc3b_word v, input int bits);
        lc3b_word m;
        m = 16'hFFFF << bits;
        return v[bits-1] ? (v | m) : (v & ~m);
    endfunction

    function automatic lc3b_nzp flags(input lc3b_word v);
        if (v[15]) return 3'b100;
        if (v == 16'h0000) return 3'b010;
        return 3'b001;
    endfunction

    function automatic lc3b_reg pick_src();
        lc3b_reg r;
        r = 3'(urand(8));
        while (ready_cyc[r] > cyc) r = 3'(urand(8));   // at most three are in flight
        return r;
    endfunction

    task automatic log_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic expect_write(input lc3b_reg dr, input lc3b_word v);
        m_regs[dr]    = v;
        ready_cyc[dr] = cyc + `LC3B_WB_LATENCY;
        wq_due.push_back(cyc + `LC3B_WB_LATENCY);
        wq_dest.push_back(dr);
        wq_data.push_back(v);
        wq_cc.push_back(flags(v));
    endtask

    task automatic idle();
        instr_valid = 1'b0;
        @(posedge clk);
        #5;
    endtask

    task automatic wait_ready(input lc3b_reg r);
        while (ready_cyc[r] > cyc) idle();
    endtask

    // drive one instruction and update the model in program order
    task automatic send(input lc3b_word ir);
        lc3b_word a, b, addr;
        instr_valid = 1'b1;
        instr       = ir;
        a           = m_regs[ir[8:6]];
        addr        = (a + (sext(ir, 6) << 1)) & 16'hFFFE;
        case (ir[15:12])
            op_add, op_and: begin
                b = ir[5] ? sext(ir, 5) : m_regs[ir[2:0]];
                expect_write(ir[11:9], (ir[15:12] == op_add) ? a + b : a & b);
            end
            op_not: expect_write(ir[11:9], ~a);
            op_shf: begin
                if (!ir[4]) b = a << ir[3:0];
                else b = (a >> ir[3:0]) | ((ir[5] && a[15]) ? ~(16'hFFFF >> ir[3:0]) : 16'h0);
                expect_write(ir[11:9], b);
            end
            op_lea: expect_write(ir[11:9], m_pc + 16'd2 + (sext(ir, 9) << 1));
            op_ldr: expect_write(ir[11:9], m_ram[addr[8:1]]);
            op_str: begin
                m_ram[addr[8:1]] = m_regs[ir[11:9]];
                sq_due.push_back(cyc + `LC3B_WB_LATENCY - 1);
                sq_addr.push_back(addr);
                sq_data.push_back(m_regs[ir[11:9]]);
            end
            default: ;                      // bubble
        endcase
        m_pc = m_pc + 16'd2;
        @(posedge clk);
        #5;
        instr_valid = 1'b0;
    endtask

    task automatic alu_random(input int unsigned dest_span);
        lc3b_reg    dr, s1, s2;
        logic [4:0] imm;
        dr  = 3'(urand(dest_span));
        s1  = pick_src();
        s2  = pick_src();
        imm = 5'(urand(32));
        case (urand(5))
            0: send({op_add, dr, s1, 3'b000, s2});
            1: send({op_add, dr, s1, 1'b1, imm});
            2: send({op_and, dr, s1, 3'b000, s2});
            3: send({op_and, dr, s1, 1'b1, imm});
            default: send({op_not, dr, s1, 6'b111111});
        endcase
    endtask

    // base = b * 128 bytes, so the offsets reach 64 words around word b * 64
    task automatic set_base(input lc3b_reg r, input logic [4:0] b);
        send({op_and, r, r, 1'b1, 5'b00000});
        wait_ready(r);
        send({op_add, r, r, 1'b1, b});
        wait_ready(r);
        send({op_shf, r, r, 2'b00, 4'd7});
        wait_ready(r);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        while (wq_due.size() != 0 || sq_due.size() != 0) idle();
        tests++;
        $display("test %-6s done at cycle %0d, %0d errors", name, cyc, errors - errs_before);
    endtask

    // retire checked entries, then present what the next edge must see
    always @(negedge clk) begin
        while (wq_due.size() != 0 && wq_due[0] < cyc) begin
            exp_cc = wq_cc.pop_front();     // dut cc loaded with that write
            void'(wq_due.pop_front());
            void'(wq_dest.pop_front());
            void'(wq_data.pop_front());
        end
        while (sq_due.size() != 0 && sq_due[0] < cyc) begin
            void'(sq_due.pop_front());
            void'(sq_addr.pop_front());
            void'(sq_data.pop_front());
        end
        exp_wr = wq_due.size() != 0 && wq_due[0] == cyc;
        exp_st = sq_due.size() != 0 && sq_due[0] == cyc;
        if (exp_wr) begin
            exp_dest = wq_dest[0];
            exp_data = wq_data[0];
        end
        if (exp_st) begin
            exp_addr  = sq_addr[0];
            exp_sdata = sq_data[0];
        end
    end

    reset_quiet: assert property (@(posedge clk)
        (reset && cyc > 0) |-> (!wb_valid && !st_valid && cc == 3'b000))
        else log_error($sformatf("%0t: output active or cc not cleared during reset", $time));
    wb_expected: assert property (@(posedge clk) disable iff (reset) wb_valid |-> exp_wr)
        else log_error($sformatf("%0t: unexpected register write to r%0d occurred",
                                 $time, $sampled(wb_dest)));
    wb_present: assert property (@(posedge clk) disable iff (reset) exp_wr |-> wb_valid)
        else log_error($sformatf("%0t: expected write to r%0d did not happen",
                                 $time, $sampled(exp_dest)));
    wb_value: assert property (@(posedge clk) disable iff (reset)
        (wb_valid && exp_wr) |-> (wb_dest == exp_dest && wb_data == exp_data))
        else log_error($sformatf("MISMATCH %0t: write r%0d=%h, expected r%0d=%h", $time,
                       $sampled(wb_dest), $sampled(wb_data), $sampled(exp_dest),
                       $sampled(exp_data)));
    st_expected: assert property (@(posedge clk) disable iff (reset) st_valid |-> exp_st)
        else log_error($sformatf("%0t: unexpected store to %h occurred", $time,
                                 $sampled(st_addr)));
    st_present: assert property (@(posedge clk) disable iff (reset) exp_st |-> st_valid)
        else log_error($sformatf("%0t: expected store to %h did not happen", $time,
                                 $sampled(exp_addr)));
    st_value: assert property (@(posedge clk) disable iff (reset)
        (st_valid && exp_st) |-> (st_addr == exp_addr && st_data == exp_sdata))
        else log_error($sformatf("MISMATCH %0t: store [%h]=%h, expected [%h]=%h", $time,
                       $sampled(st_addr), $sampled(st_data), $sampled(exp_addr),
                       $sampled(exp_sdata)));
    cc_value: assert property (@(posedge clk) disable iff (reset) cc == exp_cc)
        else log_error($sformatf("MISMATCH %0t: cc %b, expected %b", $time,
                                 $sampled(cc), $sampled(exp_cc)));

    initial begin
        int         e0;
        lc3b_reg    r;
        logic [3:0] bop;
        int         k;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = 16'h0000;
        m_pc        = `LC3B_RESET_PC;
        for (int i = 0; i < 8; i++) begin
            m_regs[i]    = 16'h0000;
            ready_cyc[i] = 0;
        end
        repeat (4) @(posedge clk);
        #5;
        reset = 1'b0;

        e0 = errors;
        repeat (4) idle();                  // nothing may come out yet
        finish_test("reset", e0);

        e0 = errors;
        for (int i = 0; i < N_ALU; i++) alu_random(8);
        finish_test("alu", e0);

        e0 = errors;
        for (int amt = 0; amt < 16; amt++) begin
            for (int s = 0; s < 3; s++) begin
                r = pick_src();
                send({op_shf, 3'(urand(8)), r, s == 2, s != 0, 4'(amt)});  // sll, srl, sra
            end
        end
        finish_test("shift", e0);

        e0 = errors;
        for (int b = 0; b < 4; b++) begin
            set_base(3'd7, 5'(b));
            for (int off = -32; off < 32; off++) begin
                alu_random(7);              // fresh store data while r7 stays the base
                r = pick_src();
                send({op_str, r, 3'd7, 6'(off)});
            end
        end
        for (int b = 0; b < 4; b++) begin
            set_base(3'd7, 5'(b));
            for (int off = -32; off < 32; off++) send({op_ldr, 3'(urand(7)), 3'd7, 6'(off)});
        end
        finish_test("mem", e0);

        e0 = errors;
        for (int i = 0; i < N_LEA; i++) begin
            send({op_lea, 3'(urand(8)), 9'(urand(512))});
            repeat (urand(3)) idle();       // gaps leave the pc alone
        end
        finish_test("lea", e0);

        e0 = errors;
        for (int i = 0; i < N_MIX / 2; i++) begin
            k   = urand(4);
            bop = (k == 0) ? op_br : (k == 1) ? op_jmp : (k == 2) ? op_trap : op_ldb;
            send({bop, 12'(urand(4096))});
            alu_random(8);
        end
        finish_test("bubble", e0);

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        wait (cyc >= LIMIT);
        $display("timeout: run still busy after %0d cycles", LIMIT);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule : tb_lc3b_pipe
